//--- Bender.yml
package:
  name: refill_path

sources:
  - files:
      - logic/refill_pkg.sv
      - logic/line_mem.sv
      - logic/refill_ctrl.sv
      - logic/beat_assembler.sv
      - logic/refill_top.sv
  - target: test
    files:
      - verification/refill_props.sv
      - verification/refill_tb.sv

//--- compile.f
logic/refill_pkg.sv
logic/line_mem.sv
logic/refill_ctrl.sv
logic/beat_assembler.sv
logic/refill_top.sv
verification/refill_props.sv
verification/refill_tb.sv

//--- logic/beat_assembler.sv
// ------------------------------
// line buffer for incoming memory beats
// slot picked by seq, full flag per slot
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

module beat_assembler (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           clear_i,       // start of a new line
    input  logic                           beat_valid_i,
    input  refill_pkg::mem_beat_t          beat_i,
    output logic [refill_pkg::LINE_W-1:0]  line_o,
    output logic                           line_full_o
);
    import refill_pkg::*;

    logic [LINE_W-1:0]         line_q;    // assembled line, beat 0 lowest
    logic [BEATS_PER_LINE-1:0] filled_q;  // one written flag per slot

    // ------------------------------
    // slot flags
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            filled_q <= '0;
        end else if (clear_i) begin
            filled_q <= '0;
        end else if (beat_valid_i) begin
            filled_q[beat_i.seq] <= 1'b1;  // any arrival order
        end
    end

    // line data stays put until overwritten by the next refill
    always_ff @(posedge clk_i) begin
        if (beat_valid_i) begin
            line_q[beat_i.seq * BEAT_W +: BEAT_W] <= beat_i.data;
        end
    end

    assign line_o      = line_q;
    assign line_full_o = &filled_q;

endmodule : beat_assembler

`default_nettype wire

//--- logic/line_mem.sv
// ------------------------------
// simulated main memory for instruction refills
// image loaded from a riscv hexdump, fixed delay
// then a four beat burst tagged with seq numbers
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

module line_mem (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    req_valid_i,   // one cycle request strobe
    input  refill_pkg::refill_req_t req_i,
    output logic                    beat_valid_o,
    output refill_pkg::mem_beat_t   beat_o
);
    import refill_pkg::*;

    // counter load so that beat 0 is sampled MEM_DELAY edges after the request edge
    // and beats go out while the counter runs 3, 2, 1, 0
    localparam logic [MEM_CNT_W-1:0] CNT_LOAD  = MEM_CNT_W'(MEM_DELAY + BEATS_PER_LINE - 2);
    localparam logic [MEM_CNT_W-1:0] CNT_BURST = MEM_CNT_W'(BEATS_PER_LINE);

    logic [BEAT_W-1:0]    mem_q [MEM_BEATS];  // word array with 4 words per line
    logic [MEM_CNT_W-1:0] cnt_q;              // delay plus burst down-counter
    logic                 active_q;           // a request is being served
    refill_req_t          addr_q;             // latched line index
    logic [SEQ_W-1:0]     seq;

    // image comes from the test hexdump with one 128 bit word per text line
    initial begin
        $readmemh(HEX_FILE, mem_q);
    end

    // ------------------------------
    // request latch and counter
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (req_valid_i && !active_q) begin  // new requests only when idle
            active_q <= 1'b1;
            cnt_q    <= CNT_LOAD;
        end else if (active_q) begin
            if (cnt_q == '0) begin
                active_q <= 1'b0;                     // last beat went out
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // line index of the request being served
    always_ff @(posedge clk_i) begin
        if (req_valid_i && !active_q) begin
            addr_q <= req_i;
        end
    end

    // ------------------------------
    // burst output
    assign seq = SEQ_W'(BEATS_PER_LINE - 1) - cnt_q[SEQ_W-1:0];  // 3..0 becomes 0..3

    assign beat_valid_o = active_q && (cnt_q < CNT_BURST);
    assign beat_o.seq   = seq;
    assign beat_o.data  = mem_q[{addr_q.line_addr, seq}];

endmodule : line_mem

`default_nettype wire

//--- logic/refill_ctrl.sv
// ------------------------------
// refill controller, one miss at a time
// accept, launch memory request, wait for full line
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

module refill_ctrl (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                req_valid_i,   // sampled only while idle
    input  refill_pkg::refill_req_t             req_i,
    input  logic                                line_full_i,   // all four slots written
    output logic                                mem_req_o,
    output refill_pkg::refill_req_t             mem_req_addr_o,
    output logic                                clear_o,       // empties the slot flags
    output logic                                busy_o,
    output logic                                resp_valid_o,
    output logic [refill_pkg::LINE_ADDR_W-1:0]  resp_addr_o
);
    import refill_pkg::*;

    typedef enum logic [1:0] {
        IDLE,    // waiting for a miss
        LAUNCH,  // memory request goes out
        FILL     // collecting beats
    } state_e;

    state_e      state_q;
    state_e      state_d;
    refill_req_t addr_q;   // address of the pending miss
    logic        accept;
    logic        done;

    assign accept = req_valid_i && (state_q == IDLE);  // requests while busy are dropped
    assign done   = (state_q == FILL) && line_full_i;

    // ------------------------------
    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LAUNCH;
                end
            end
            LAUNCH: state_d = FILL;       // request is out this cycle
            FILL: begin
                if (line_full_i) begin
                    state_d = IDLE;       // response cycle, free again next
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address latch
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= req_i;
        end
    end

    // ------------------------------
    // outputs
    assign clear_o        = accept;              // old flags go at the accept edge
    assign mem_req_o      = (state_q == LAUNCH);  // one cycle after acceptance
    assign mem_req_addr_o = addr_q;
    assign busy_o         = (state_q != IDLE);   // high up to and incl. the response cycle
    assign resp_valid_o   = done;
    assign resp_addr_o    = addr_q.line_addr;

endmodule : refill_ctrl

`default_nettype wire

//--- logic/refill_pkg.sv
// ------------------------------
// shared definitions of the refill path
// widths, memory timing, image file name
// and the request, beat and response structs
// ------------------------------

`default_nettype none

package refill_pkg;

    // ------------------------------
    // sizes
    localparam int unsigned BEAT_W         = 128;               // one memory word
    localparam int unsigned BEATS_PER_LINE = 4;
    localparam int unsigned LINE_W         = BEAT_W * BEATS_PER_LINE;  // 512
    localparam int unsigned SEQ_W          = 2;                 // beat number 0..3
    localparam int unsigned LINE_ADDR_W    = 4;                 // 16 lines
    localparam int unsigned MEM_BEATS      = 64;                // 16 lines of 4 beats

    // ------------------------------
    // timing
    localparam int unsigned MEM_DELAY      = 6;                 // request edge to first beat
    localparam int unsigned REFILL_LATENCY = MEM_DELAY + 5;     // accept to response, 11
    localparam int unsigned MEM_CNT_W      = $clog2(MEM_DELAY + BEATS_PER_LINE);

    localparam string HEX_FILE = "test.riscv.hex";              // riscv test hexdump

    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
    } refill_req_t;

    typedef struct packed {
        logic [BEAT_W-1:0] data;
        logic [SEQ_W-1:0]  seq;                                 // slot of this beat in the line
    } mem_beat_t;

    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [LINE_W-1:0]      line;                           // beat 0 in the low bits
    } refill_resp_t;

endpackage : refill_pkg

`default_nettype wire

//--- logic/refill_top.sv
// ------------------------------
// instruction refill path top level
// controller, main memory model, beat assembler
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

module refill_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     req_valid_i,
    input  refill_pkg::refill_req_t  req_i,
    output logic                     busy_o,
    output logic                     resp_valid_o,
    output refill_pkg::refill_resp_t resp_o
);
    import refill_pkg::*;

    logic                   mem_req;
    refill_req_t            mem_req_addr;
    logic                   beat_valid;
    mem_beat_t              beat;
    logic                   clear;
    logic                   line_full;
    logic [LINE_W-1:0]      line;
    logic [LINE_ADDR_W-1:0] resp_addr;

    // ------------------------------
    // miss control
    refill_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .line_full_i    (line_full),
        .mem_req_o      (mem_req),
        .mem_req_addr_o (mem_req_addr),
        .clear_o        (clear),
        .busy_o         (busy_o),
        .resp_valid_o   (resp_valid_o),
        .resp_addr_o    (resp_addr)
    );

    line_mem u_mem (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (mem_req),
        .req_i        (mem_req_addr),
        .beat_valid_o (beat_valid),
        .beat_o       (beat)
    );

    beat_assembler u_asm (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .clear_i      (clear),
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .line_o       (line),
        .line_full_o  (line_full)
    );

    assign resp_o.line_addr = resp_addr;
    assign resp_o.line      = line;  // valid with resp_valid_o

endmodule : refill_top

`default_nettype wire

//--- test.riscv.hex
// one 128 bit word per line, four rv32 instructions, lowest address in the low 32 bits
// 64 words in address order, four consecutive words make one 512 bit cache line
30529073020282930000029700000093
000000130ff0000ff140257300100093
0000806700112623ff01011300200093
0101011300c120830000001300300093
002081b3002001130010011300400093
0000a28340208233002081b300500093
fe0718e3005120230000a28300600093
00050513000005170000806700700093
00a5a0230015859300b5063300800093
02b506630005a503fff5051300900093
00d777b340b6073300c586b300a00093
001599130107c8b300f6e83300b00093
fe5ff06f0040006f4015d99300c00093
3412907380028293000022b700d00093
0000007305d0089300100f9300e00093
30200073000000130ff0000f00f00093
00000297020282933052907301000093
f140257300000013ff01011301100093
0011262300c120830101011301200093
00200113002081b34020823301300093
0000a28300512023fe0718e301400093
00008067000005170005051301500093
00b5063300158593fff5051301600093
00a5a0230005a50302b5066301700093
00c586b340b6073300d777b301800093
00f6e8330107c8b30015991301900093
4015d9930040006ffe5ff06f01a00093
000022b7800282933412907301b00093
f140257300100f9305d0089301c00093
00000073302000730000001301d00093
ff010113001126230000001301e00093
00c12083010101130000806701f00093
30529073020282930000029702000093
000000130ff0000ff140257302100093
0000806700112623ff01011302200093
0101011300c120830000001302300093
002081b3002001130010011302400093
0000a28340208233002081b302500093
fe0718e3005120230000a28302600093
00050513000005170000806702700093
00a5a0230015859300b5063302800093
02b506630005a503fff5051302900093
00d777b340b6073300c586b302a00093
001599130107c8b300f6e83302b00093
fe5ff06f0040006f4015d99302c00093
3412907380028293000022b702d00093
0000007305d0089300100f9302e00093
30200073000000130ff0000f02f00093
00000297020282933052907303000093
f140257300000013ff01011303100093
0011262300c120830101011303200093
00200113002081b34020823303300093
0000a28300512023fe0718e303400093
00008067000005170005051303500093
00b5063300158593fff5051303600093
00a5a0230005a50302b5066303700093
00c586b340b6073300d777b303800093
00f6e8330107c8b30015991303900093
4015d9930040006ffe5ff06f03a00093
000022b7800282933412907303b00093
f140257300100f9305d0089303c00093
00000073302000730000001303d00093
ff010113001126230000001303e00093
00c12083010101130000806703f00093

//--- verification/refill_props.sv
// ------------------------------
// concurrent checks on the refill path
// response latency, busy window, reset values
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

module refill_props (
    input logic clk_i,
    input logic rstn_i,
    input logic req_valid_i,
    input logic busy_i,
    input logic resp_valid_i
);
    import refill_pkg::*;

    int   fail_cnt = 0;  // failed assertion count
    logic accept;

    assign accept = req_valid_i && !busy_i;  // request seen while idle

    // ------------------------------
    // latency
    a_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept |-> ##REFILL_LATENCY resp_valid_i)
        else begin
            $error("no response %0d cycles after an accepted request", REFILL_LATENCY);
            fail_cnt++;
        end

    // no response without a matching request
    a_no_early: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |-> $past(accept, REFILL_LATENCY))
        else begin
            $error("response without an accepted request %0d cycles before", REFILL_LATENCY);
            fail_cnt++;
        end

    // ------------------------------
    // busy window
    a_busy_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept |=> busy_i)
        else begin
            $error("busy did not rise after an accepted request");
            fail_cnt++;
        end

    a_busy_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        busy_i && !resp_valid_i |=> busy_i)  // held until the response cycle
        else begin
            $error("busy dropped before the response");
            fail_cnt++;
        end

    a_busy_drop: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |-> busy_i ##1 !busy_i)
        else begin
            $error("busy not high in the response cycle or not low right after it");
            fail_cnt++;
        end

    // reset values
    a_reset_low: assert property (@(posedge clk_i)
        !rstn_i |-> !busy_i && !resp_valid_i)
        else begin
            $error("busy or response high during reset");
            fail_cnt++;
        end

    a_reset_exit: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !busy_i && !resp_valid_i)
        else begin
            $error("busy or response high in the first cycle after reset");
            fail_cnt++;
        end

endmodule : refill_props

`default_nettype wire

//--- verification/refill_tb.sv
// ------------------------------
// testbench for the instruction refill path
// random miss stream with requests while busy
// line data and address checks, timeout
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

module refill_tb;
    import refill_pkg::*;

    localparam int N_REQ          = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = N_REQ * (REFILL_LATENCY + 4) + 400;  // 1000

    logic         clk_i;
    logic         rstn_i;
    logic         req_valid_i;
    refill_req_t  req_i;
    logic         busy_o;
    logic         resp_valid_o;
    refill_resp_t resp_o;

    logic [BEAT_W-1:0]      img [MEM_BEATS];  // reference copy of the memory image
    logic [LINE_ADDR_W-1:0] exp_q [$];        // accepted addresses, oldest first
    logic [LINE_ADDR_W-1:0] exp_addr;
    logic [LINE_W-1:0]      exp_line;
    integer                 seed;
    int                     err_cnt;
    int                     acc_cnt;
    int                     resp_cnt;
    int                     cyc;

    refill_top DUT (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .busy_o       (busy_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

    bind refill_top refill_props u_props (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .busy_i       (busy_o),
        .resp_valid_i (resp_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    // four image words of a line, beat 0 lowest
    function automatic logic [LINE_W-1:0] line_from_image(input logic [LINE_ADDR_W-1:0] addr);
        logic [LINE_W-1:0] l;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            l[b*BEAT_W +: BEAT_W] = img[addr*BEATS_PER_LINE + b];
        end
        return l;
    endfunction

    // ------------------------------
    // stimulus, called on a falling edge
    task automatic send_request(input logic [LINE_ADDR_W-1:0] addr);
        req_valid_i     = 1'b1;
        req_i.line_addr = addr;
        exp_q.push_back(addr);
        acc_cnt++;
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    // request that must be dropped, sent only while busy
    task automatic poke_while_busy(input logic [LINE_ADDR_W-1:0] addr, input int delay);
        repeat (delay) @(negedge clk_i);
        if (busy_o) begin
            req_valid_i     = 1'b1;
            req_i.line_addr = ~addr;  // never the pending address
            @(negedge clk_i);
            req_valid_i = 1'b0;
        end
    endtask

    // ------------------------------
    // response checks
    always @(negedge clk_i) begin
        if (rstn_i && resp_valid_o) begin
            resp_cnt++;
            assert (exp_q.size() != 0) else begin
                $display("time %0t: response arrived with no request pending", $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_addr = exp_q.pop_front();
                exp_line = line_from_image(exp_addr);
                assert (resp_o.line_addr === exp_addr) else begin
                    $display("MISMATCH time %0t resp_o.line_addr expected %h got %h",
                             $time, exp_addr, resp_o.line_addr);
                    err_cnt++;
                end
                assert (resp_o.line === exp_line) else begin
                    $display("MISMATCH time %0t resp_o.line expected %h got %h",
                             $time, exp_line, resp_o.line);
                    err_cnt++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        seed        = 6;
        err_cnt     = 0;
        acc_cnt     = 0;
        resp_cnt    = 0;
        rstn_i      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        $readmemh(HEX_FILE, img);
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (2) @(negedge clk_i);

        for (int n = 0; n < N_REQ; n++) begin
            while (busy_o) @(negedge clk_i);
            r = $random(seed);
            repeat (r[5:4]) @(negedge clk_i);  // idle gap 0..3, zero is back to back
            send_request(r[LINE_ADDR_W-1:0]);
            if (r[8]) begin
                poke_while_busy(r[LINE_ADDR_W-1:0], int'(r[15:12]) % 10);
            end
        end

        while (exp_q.size() != 0) @(negedge clk_i);
        repeat (4) @(negedge clk_i);
        assert (resp_cnt == acc_cnt) else begin
            $display("MISMATCH time %0t response count expected %0d got %0d",
                     $time, acc_cnt, resp_cnt);
            err_cnt++;
        end

        $display("check errors: %0d, assertion errors: %0d, accepted: %0d, responses: %0d",
                 err_cnt, DUT.u_props.fail_cnt, acc_cnt, resp_cnt);
        if (err_cnt + DUT.u_props.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // ------------------------------
    // run limit
    initial begin
        cyc = 0;
        while (cyc < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cyc++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule : refill_tb

`default_nettype wire
